//--- source/bridge_settings.svh
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

`define NUM_CACHE             2
`define MSHR_ELS              4
`define BLOCK_WORDS           8
`define DATA_WIDTH            32
`define DRAM_DATA_WIDTH       64
`define NUM_REQ               (`BLOCK_WORDS * `DATA_WIDTH / `DRAM_DATA_WIDTH)  // beats per block
`define ADDR_WIDTH            32
`define CACHE_BANK_ADDR_WIDTH 24  // bits a bank really decodes
`define DRAM_ADDR_WIDTH       28
`define EVICT_LUT_SIZE        16
`define REQ_FIFO_DEPTH        8
`define RET_FIFO_DEPTH        32
`define DRAM_BYTE_OFFSET      $clog2(`DRAM_DATA_WIDTH / 8)
`define LINE_LSB              (`DRAM_BYTE_OFFSET + $clog2(`NUM_REQ))
`define LINE_WIDTH            (`CACHE_BANK_ADDR_WIDTH - `LINE_LSB)

`endif

//--- source/dma_pkt_pkg.sv
`default_nettype none

`include "bridge_settings.svh"

// cache side of the bridge
package dma_pkt_pkg;

  typedef logic [$clog2(`NUM_CACHE)-1:0] cache_id_t;
  typedef logic [$clog2(`MSHR_ELS)-1:0]  mshr_id_t;

  // one refill or eviction request from a cache bank
  typedef struct packed {
    logic                   write_not_read;  // 1 = eviction
    mshr_id_t               mshr_id;
    logic [`ADDR_WIDTH-1:0] addr;            // byte address
  } dma_pkt_t;

endpackage

`default_nettype wire

//--- source/dram_chan_pkg.sv
`default_nettype none

`include "bridge_settings.svh"

// dram channel side of the bridge
package dram_chan_pkg;

  // {cache id, zero pad, line, beat, byte offset}
  typedef logic [`DRAM_ADDR_WIDTH-1:0] dram_addr_t;

  typedef logic [`LINE_WIDTH-1:0]       line_addr_t;
  typedef logic [$clog2(`NUM_REQ)-1:0]  beat_idx_t;
  typedef logic [`DRAM_DATA_WIDTH-1:0]  dram_data_t;

  typedef logic [$clog2(`EVICT_LUT_SIZE)-1:0] evict_idx_t;  // evict table slot

endpackage

`default_nettype wire

//--- source/bridge_if.sv
`default_nettype none
`timescale 1ns/10ps

// arbiter to splitter, valid-yumi
interface pkt_if import dma_pkt_pkg::*;;
  logic      valid;
  logic      yumi;   // only while valid, takes the packet this cycle
  dma_pkt_t  pkt;
  cache_id_t cache_id;

  modport arbiter  (output valid, pkt, cache_id, input yumi);
  modport splitter (input valid, pkt, cache_id, output yumi);
endinterface

// splitter to request queue
interface req_enq_if import dma_pkt_pkg::*, dram_chan_pkg::*;;
  logic       enq;             // never while full
  logic       full;
  logic       write_not_read;
  mshr_id_t   mshr_id;
  dram_addr_t addr;

  modport splitter (output enq, write_not_read, mshr_id, addr, input full);
  modport queue    (input enq, write_not_read, mshr_id, addr, output full);
endinterface

`default_nettype wire

//--- source/dma_req_arbiter.sv
`default_nettype none
`timescale 1ns/10ps

`include "bridge_settings.svh"

module dma_req_arbiter import dma_pkt_pkg::*; (
  input  wire logic                       core_clk_i,
  input  wire logic                       core_reset_i,
  input  wire dma_pkt_t [`NUM_CACHE-1:0]  pkt_i,
  input  wire logic     [`NUM_CACHE-1:0]  pkt_v_i,
  output logic          [`NUM_CACHE-1:0]  pkt_yumi_o,
  pkt_if.arbiter                          out_o
);

  cache_id_t ptr_r;   // highest priority cache
  cache_id_t winner;
  logic      found;

  // first valid cache at or after the pointer
  always_comb begin
    int idx;
    found  = 1'b0;
    winner = ptr_r;
    for (int i = 0; i < `NUM_CACHE; i++) begin
      idx = (int'(ptr_r) + i) % `NUM_CACHE;
      if (!found && pkt_v_i[idx]) begin
        found  = 1'b1;
        winner = cache_id_t'(idx);
      end
    end
  end

  assign out_o.valid    = found;
  assign out_o.pkt      = pkt_i[winner];
  assign out_o.cache_id = winner;

  always_comb begin
    pkt_yumi_o = '0;
    if (out_o.yumi)
      pkt_yumi_o[winner] = 1'b1;  // yumi goes back to the granted bank
  end

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      ptr_r <= '0;
    end else if (out_o.yumi) begin
      ptr_r <= (winner == cache_id_t'(`NUM_CACHE - 1)) ? '0 : cache_id_t'(winner + 1'b1);
    end
  end

endmodule

`default_nettype wire

//--- source/req_splitter.sv
`default_nettype none
`timescale 1ns/10ps

`include "bridge_settings.svh"

module req_splitter
  import dma_pkt_pkg::*;
  import dram_chan_pkg::*;
(
  input  wire logic core_clk_i,
  input  wire logic core_reset_i,
  pkt_if.splitter   in_i,
  req_enq_if.splitter enq_o
);

  localparam int CID_W = $bits(cache_id_t);
  localparam int PAD_W = `DRAM_ADDR_WIDTH - `CACHE_BANK_ADDR_WIDTH - CID_W;

  beat_idx_t  cnt_r;    // next beat to enqueue, 0 = idle
  dma_pkt_t   pkt_r;    // saved packet for beats 1 and up
  cache_id_t  cid_r;
  dma_pkt_t   cur_pkt;
  cache_id_t  cur_cid;
  line_addr_t cur_line;

  always_comb begin
    in_i.yumi  = 1'b0;
    enq_o.enq  = 1'b0;
    cur_pkt    = pkt_r;
    cur_cid    = cid_r;
    if (cnt_r == '0) begin
      // beat 0 straight from the arbiter
      cur_pkt = in_i.pkt;
      cur_cid = in_i.cache_id;
      if (in_i.valid && !enq_o.full) begin
        in_i.yumi = 1'b1;
        enq_o.enq = 1'b1;
      end
    end else if (!enq_o.full) begin
      enq_o.enq = 1'b1;
    end
  end

  assign cur_line = cur_pkt.addr[`CACHE_BANK_ADDR_WIDTH-1:`LINE_LSB];

  assign enq_o.write_not_read = cur_pkt.write_not_read;
  assign enq_o.mshr_id        = cur_pkt.mshr_id;
  assign enq_o.addr           = {cur_cid, {PAD_W{1'b0}}, cur_line, cnt_r,
                                 {`DRAM_BYTE_OFFSET{1'b0}}};

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      cnt_r <= '0;
    end else if (enq_o.enq) begin
      cnt_r <= (cnt_r == beat_idx_t'(`NUM_REQ - 1)) ? '0 : beat_idx_t'(cnt_r + 1'b1);
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (in_i.yumi) begin
      pkt_r <= in_i.pkt;
      cid_r <= in_i.cache_id;
    end
  end

endmodule

`default_nettype wire

//--- source/dram_req_queue.sv
`default_nettype none
`timescale 1ns/10ps

`include "bridge_settings.svh"

module dram_req_queue
  import dma_pkt_pkg::*;
  import dram_chan_pkg::*;
(
  input  wire logic core_clk_i,
  input  wire logic core_reset_i,
  input  wire logic stall_i,          // hazard from the tracker
  input  wire logic dram_req_yumi_i,
  req_enq_if.queue  enq_i,
  output logic       head_v_o,
  output logic       dram_req_v_o,
  output logic       dram_write_not_read_o,
  output mshr_id_t   head_mshr_id_o,
  output dram_addr_t dram_ch_addr_o,
  output logic       req_fire_o
);

  localparam int PTR_W = $clog2(`REQ_FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  logic       wnr_mem  [`REQ_FIFO_DEPTH];
  mshr_id_t   mshr_mem [`REQ_FIFO_DEPTH];
  dram_addr_t addr_mem [`REQ_FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_r, rd_ptr_r;
  logic [CNT_W-1:0] count_r;
  logic             deq;

  assign enq_i.full = (count_r == CNT_W'(`REQ_FIFO_DEPTH));
  assign head_v_o   = (count_r != '0);

  assign dram_req_v_o          = head_v_o & ~stall_i;  // hidden while stalled
  assign dram_write_not_read_o = wnr_mem[rd_ptr_r];
  assign head_mshr_id_o        = mshr_mem[rd_ptr_r];
  assign dram_ch_addr_o        = addr_mem[rd_ptr_r];

  assign deq        = dram_req_v_o & dram_req_yumi_i;
  assign req_fire_o = deq;

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (enq_i.enq) wr_ptr_r <= wr_ptr_r + 1'b1;
      if (deq)       rd_ptr_r <= rd_ptr_r + 1'b1;
      case ({enq_i.enq, deq})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (enq_i.enq) begin
      wnr_mem[wr_ptr_r]  <= enq_i.write_not_read;
      mshr_mem[wr_ptr_r] <= enq_i.mshr_id;
      addr_mem[wr_ptr_r] <= enq_i.addr;
    end
  end

endmodule

`default_nettype wire

//--- source/miss_tracker.sv
`default_nettype none
`timescale 1ns/10ps

`include "bridge_settings.svh"

module miss_tracker
  import dma_pkt_pkg::*;
  import dram_chan_pkg::*;
(
  input  wire logic       core_clk_i,
  input  wire logic       core_reset_i,
  input  wire logic       head_v_i,
  input  wire logic       head_write_not_read_i,
  input  wire mshr_id_t   head_mshr_id_i,
  input  wire dram_addr_t head_addr_i,
  input  wire logic       req_fire_i,
  input  wire logic       dram_data_v_i,
  input  wire dram_addr_t dram_rd_ch_addr_i,
  input  wire logic       dram_write_done_i,
  input  wire dram_addr_t dram_wd_ch_addr_i,
  output logic            stall_o,
  output mshr_id_t        rd_mshr_id_o
);

  localparam int        CID_W     = $bits(cache_id_t);
  localparam beat_idx_t LAST_BEAT = beat_idx_t'(`NUM_REQ - 1);

  // refill table, indexed by mshr id
  logic       ref_v_r    [`NUM_CACHE][`MSHR_ELS];
  line_addr_t ref_line_r [`NUM_CACHE][`MSHR_ELS];
  beat_idx_t  ref_cnt_r  [`NUM_CACHE][`MSHR_ELS];  // beats returned so far
  // evict table
  logic       ev_v_r     [`NUM_CACHE][`EVICT_LUT_SIZE];
  line_addr_t ev_line_r  [`NUM_CACHE][`EVICT_LUT_SIZE];
  beat_idx_t  ev_cnt_r   [`NUM_CACHE][`EVICT_LUT_SIZE];  // write-dones so far

  cache_id_t  head_cid, rd_cid, wd_cid;
  line_addr_t head_line, rd_line, wd_line;
  beat_idx_t  head_beat;
  logic       raw_hit, ev_avail, rd_hit, wd_hit, alloc;
  evict_idx_t alloc_idx, wd_idx;
  mshr_id_t   rd_idx;

  assign head_cid  = head_addr_i[`DRAM_ADDR_WIDTH-1 -: CID_W];
  assign head_line = head_addr_i[`LINE_LSB +: `LINE_WIDTH];
  assign head_beat = head_addr_i[`DRAM_BYTE_OFFSET +: $bits(beat_idx_t)];
  assign rd_cid    = dram_rd_ch_addr_i[`DRAM_ADDR_WIDTH-1 -: CID_W];
  assign rd_line   = dram_rd_ch_addr_i[`LINE_LSB +: `LINE_WIDTH];
  assign wd_cid    = dram_wd_ch_addr_i[`DRAM_ADDR_WIDTH-1 -: CID_W];
  assign wd_line   = dram_wd_ch_addr_i[`LINE_LSB +: `LINE_WIDTH];

  // scan high to low so the lowest match wins
  always_comb begin
    raw_hit   = 1'b0;
    ev_avail  = 1'b0;
    alloc_idx = '0;
    wd_hit    = 1'b0;
    wd_idx    = '0;
    for (int i = `EVICT_LUT_SIZE - 1; i >= 0; i--) begin
      if (ev_v_r[head_cid][i] && ev_line_r[head_cid][i] == head_line)
        raw_hit = 1'b1;
      if (!ev_v_r[head_cid][i]) begin
        ev_avail  = 1'b1;
        alloc_idx = evict_idx_t'(i);
      end
      if (ev_v_r[wd_cid][i] && ev_line_r[wd_cid][i] == wd_line) begin
        wd_hit = 1'b1;
        wd_idx = evict_idx_t'(i);
      end
    end
  end

  always_comb begin
    rd_hit = 1'b0;
    rd_idx = '0;
    for (int i = `MSHR_ELS - 1; i >= 0; i--) begin
      if (ref_v_r[rd_cid][i] && ref_line_r[rd_cid][i] == rd_line) begin
        rd_hit = 1'b1;
        rd_idx = mshr_id_t'(i);
      end
    end
  end

  assign rd_mshr_id_o = rd_idx;
  assign alloc        = req_fire_i & (head_beat == '0);  // first beat of a line leaves

  // read behind a pending eviction, or eviction with nowhere to go
  assign stall_o = head_v_i & ((~head_write_not_read_i & raw_hit)
                 | (head_write_not_read_i & (head_beat == '0) & ~ev_avail));

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      ref_v_r   <= '{default: '0};
      ref_cnt_r <= '{default: '0};
      ev_v_r    <= '{default: '0};
      ev_cnt_r  <= '{default: '0};
    end else begin
      if (alloc && !head_write_not_read_i) ref_v_r[head_cid][head_mshr_id_i] <= 1'b1;
      if (alloc && head_write_not_read_i)  ev_v_r[head_cid][alloc_idx] <= 1'b1;
      if (dram_data_v_i && rd_hit) begin
        if (ref_cnt_r[rd_cid][rd_idx] == LAST_BEAT) begin
          ref_v_r[rd_cid][rd_idx]   <= 1'b0;
          ref_cnt_r[rd_cid][rd_idx] <= '0;
        end else begin
          ref_cnt_r[rd_cid][rd_idx] <= beat_idx_t'(ref_cnt_r[rd_cid][rd_idx] + 1'b1);
        end
      end
      if (dram_write_done_i && wd_hit) begin
        if (ev_cnt_r[wd_cid][wd_idx] == LAST_BEAT) begin
          ev_v_r[wd_cid][wd_idx]   <= 1'b0;
          ev_cnt_r[wd_cid][wd_idx] <= '0;
        end else begin
          ev_cnt_r[wd_cid][wd_idx] <= beat_idx_t'(ev_cnt_r[wd_cid][wd_idx] + 1'b1);
        end
      end
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (alloc) begin
      if (!head_write_not_read_i) ref_line_r[head_cid][head_mshr_id_i] <= head_line;
      else                        ev_line_r[head_cid][alloc_idx] <= head_line;
    end
  end

endmodule

`default_nettype wire

//--- source/read_return.sv
`default_nettype none
`timescale 1ns/10ps

`include "bridge_settings.svh"

module read_return
  import dma_pkt_pkg::*;
  import dram_chan_pkg::*;
(
  input  wire logic                    core_clk_i,
  input  wire logic                    core_reset_i,
  input  wire logic                    dram_data_v_i,
  input  wire dram_data_t              dram_data_i,
  input  wire dram_addr_t              dram_rd_ch_addr_i,
  input  wire mshr_id_t                mshr_id_i,         // from the refill table
  input  wire logic [`NUM_CACHE-1:0]   dma_data_ready_i,
  output dram_data_t [`NUM_CACHE-1:0]  dma_data_o,
  output mshr_id_t   [`NUM_CACHE-1:0]  dma_mshr_id_o,
  output logic       [`NUM_CACHE-1:0]  dma_data_v_o
);

  localparam int PTR_W = $clog2(`RET_FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;
  localparam int CID_W = $bits(cache_id_t);

  dram_data_t data_mem [`RET_FIFO_DEPTH];
  mshr_id_t   mshr_mem [`RET_FIFO_DEPTH];
  cache_id_t  cid_mem  [`RET_FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_r, rd_ptr_r;
  logic [CNT_W-1:0] count_r;  // sized for every outstanding beat
  cache_id_t        head_cid;
  logic             head_v, deq;

  assign head_v   = (count_r != '0);
  assign head_cid = cid_mem[rd_ptr_r];
  assign deq      = head_v & dma_data_ready_i[head_cid];  // other banks wait behind

  always_comb begin
    for (int c = 0; c < `NUM_CACHE; c++) begin
      dma_data_o[c]    = data_mem[rd_ptr_r];
      dma_mshr_id_o[c] = mshr_mem[rd_ptr_r];
      dma_data_v_o[c]  = head_v & (head_cid == cache_id_t'(c));
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (dram_data_v_i) wr_ptr_r <= wr_ptr_r + 1'b1;
      if (deq)           rd_ptr_r <= rd_ptr_r + 1'b1;
      count_r <= count_r + CNT_W'(dram_data_v_i) - CNT_W'(deq);
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (dram_data_v_i) begin
      data_mem[wr_ptr_r] <= dram_data_i;
      mshr_mem[wr_ptr_r] <= mshr_id_i;
      cid_mem[wr_ptr_r]  <= dram_rd_ch_addr_i[`DRAM_ADDR_WIDTH-1 -: CID_W];
    end
  end

endmodule

`default_nettype wire

//--- source/dram_bridge_top.sv
`default_nettype none
`timescale 1ns/10ps

`include "bridge_settings.svh"

module dram_bridge_top
  import dma_pkt_pkg::*;
  import dram_chan_pkg::*;
(
  input  wire logic                        core_clk_i,
  input  wire logic                        core_reset_i,
  // cache banks
  input  wire dma_pkt_t [`NUM_CACHE-1:0]   dma_pkt_i,
  input  wire logic     [`NUM_CACHE-1:0]   dma_pkt_v_i,
  output logic          [`NUM_CACHE-1:0]   dma_pkt_yumi_o,
  output dram_data_t    [`NUM_CACHE-1:0]   dma_data_o,
  output mshr_id_t      [`NUM_CACHE-1:0]   dma_mshr_id_o,
  output logic          [`NUM_CACHE-1:0]   dma_data_v_o,
  input  wire logic     [`NUM_CACHE-1:0]   dma_data_ready_i,
  // dram channel
  output logic                             dram_req_v_o,
  output logic                             dram_write_not_read_o,
  output dram_addr_t                       dram_ch_addr_o,
  input  wire logic                        dram_req_yumi_i,
  input  wire logic                        dram_write_done_i,
  input  wire dram_addr_t                  dram_wd_ch_addr_i,
  input  wire logic                        dram_data_v_i,
  input  wire dram_data_t                  dram_data_i,
  input  wire dram_addr_t                  dram_rd_ch_addr_i
);

  pkt_if     pkt_bus ();
  req_enq_if enq_bus ();

  logic     head_v, req_fire, stall;
  mshr_id_t head_mshr_id, rd_mshr_id;

  dma_req_arbiter u_arbiter (
    .core_clk_i, .core_reset_i,
    .pkt_i(dma_pkt_i), .pkt_v_i(dma_pkt_v_i), .pkt_yumi_o(dma_pkt_yumi_o),
    .out_o(pkt_bus)
  );

  req_splitter u_splitter (.core_clk_i, .core_reset_i, .in_i(pkt_bus), .enq_o(enq_bus));

  dram_req_queue u_req_queue (
    .core_clk_i, .core_reset_i,
    .stall_i(stall), .dram_req_yumi_i, .enq_i(enq_bus),
    .head_v_o(head_v), .dram_req_v_o, .dram_write_not_read_o,
    .head_mshr_id_o(head_mshr_id), .dram_ch_addr_o, .req_fire_o(req_fire)
  );

  // tracker watches the queue head through the dram port signals
  miss_tracker u_tracker (
    .core_clk_i, .core_reset_i,
    .head_v_i(head_v), .head_write_not_read_i(dram_write_not_read_o),
    .head_mshr_id_i(head_mshr_id), .head_addr_i(dram_ch_addr_o), .req_fire_i(req_fire),
    .dram_data_v_i, .dram_rd_ch_addr_i, .dram_write_done_i, .dram_wd_ch_addr_i,
    .stall_o(stall), .rd_mshr_id_o(rd_mshr_id)
  );

  read_return u_read_return (
    .core_clk_i, .core_reset_i,
    .dram_data_v_i, .dram_data_i, .dram_rd_ch_addr_i, .mshr_id_i(rd_mshr_id),
    .dma_data_ready_i, .dma_data_o, .dma_mshr_id_o, .dma_data_v_o
  );

endmodule

`default_nettype wire

//--- tb/tb_dram_bridge.sv
`default_nettype none
`timescale 1ns/10ps

`include "bridge_settings.svh"

module tb_dram_bridge import dma_pkt_pkg::*, dram_chan_pkg::*;;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_TESTS  = 5;
  localparam int WAIT_LIMIT = 200;  // cycles per wait and per test

  logic                        core_clk_i        = 1'b0;
  logic                        core_reset_i      = 1'b1;
  dma_pkt_t   [`NUM_CACHE-1:0] dma_pkt_i         = '0;
  logic       [`NUM_CACHE-1:0] dma_pkt_v_i       = '0;
  logic       [`NUM_CACHE-1:0] dma_pkt_yumi_o;
  dram_data_t [`NUM_CACHE-1:0] dma_data_o;
  mshr_id_t   [`NUM_CACHE-1:0] dma_mshr_id_o;
  logic       [`NUM_CACHE-1:0] dma_data_v_o;
  logic       [`NUM_CACHE-1:0] dma_data_ready_i  = '1;
  logic                        dram_req_v_o;
  logic                        dram_write_not_read_o;
  dram_addr_t                  dram_ch_addr_o;
  logic                        dram_req_yumi_i   = 1'b0;
  logic                        dram_write_done_i = 1'b0;
  dram_addr_t                  dram_wd_ch_addr_i = '0;
  logic                        dram_data_v_i     = 1'b0;
  dram_data_t                  dram_data_i       = '0;
  dram_addr_t                  dram_rd_ch_addr_i = '0;

  logic       yumi_en  = 1'b1;  // dram model accepts requests
  logic       wd_en    = 1'b1;  // dram model sends write-dones
  int         wd_total = 0;
  dram_addr_t rd_pend_q[$];
  dram_addr_t wr_pend_q[$];
  logic       req_wnr_q[$];
  dram_addr_t req_addr_q[$];
  int         req_wd_q[$];      // write-dones sent before each request fired
  cache_id_t  grant_q[$];
  cache_id_t  ret_cid_q[$];
  dram_data_t ret_data_q[$];
  mshr_id_t   ret_mshr_q[$];
  int         errors       = 0;
  int         failed_tests = 0;

  dram_bridge_top u_dut (.*);

  always #(CLK_PERIOD / 2) core_clk_i = ~core_clk_i;

  // {cache id, 3 pad bits, line = byte addr [23:5], beat, 3 offset bits}
  function automatic dram_addr_t exp_addr(input cache_id_t cid, input logic [31:0] a,
                                          input int beat);
    return {cid, 3'b000, a[23:5], beat_idx_t'(beat), 3'b000};
  endfunction

  function automatic dram_data_t data_of(input dram_addr_t a);
    return {4'h5, a, 4'ha, ~a};
  endfunction

  function automatic int count_rets(input cache_id_t cid);
    int n = 0;
    foreach (ret_cid_q[i]) begin
      if (ret_cid_q[i] == cid)
        n++;
    end
    return n;
  endfunction

  // dram model and monitors, all on pre-edge values
  always @(posedge core_clk_i) begin
    if (!core_reset_i) begin
      if (dram_req_v_o && dram_req_yumi_i) begin
        req_wnr_q.push_back(dram_write_not_read_o);
        req_addr_q.push_back(dram_ch_addr_o);
        req_wd_q.push_back(wd_total);
        if (dram_write_not_read_o)
          wr_pend_q.push_back(dram_ch_addr_o);
        else
          rd_pend_q.push_back(dram_ch_addr_o);
      end
      for (int c = 0; c < `NUM_CACHE; c++) begin
        if (dma_pkt_yumi_o[c])
          grant_q.push_back(cache_id_t'(c));
        if (dma_data_v_o[c] && dma_data_ready_i[c]) begin
          ret_cid_q.push_back(cache_id_t'(c));
          ret_data_q.push_back(dma_data_o[c]);
          ret_mshr_q.push_back(dma_mshr_id_o[c]);
        end
      end
      if (rd_pend_q.size() != 0) begin  // oldest read first
        dram_data_v_i     <= 1'b1;
        dram_rd_ch_addr_i <= rd_pend_q[0];
        dram_data_i       <= data_of(rd_pend_q[0]);
        rd_pend_q.delete(0);
      end else begin
        dram_data_v_i <= 1'b0;
      end
      if (wd_en && wr_pend_q.size() != 0) begin
        dram_write_done_i <= 1'b1;
        dram_wd_ch_addr_i <= wr_pend_q[0];
        wr_pend_q.delete(0);
        wd_total++;
      end else begin
        dram_write_done_i <= 1'b0;
      end
      // never two yumis in a row, so valid is always still up
      dram_req_yumi_i <= yumi_en && dram_req_v_o && !dram_req_yumi_i
                         && ($urandom_range(3) != 0);
    end
  end

  task automatic report_problem(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  task automatic check_addr(input string name, input dram_addr_t got, input dram_addr_t exp);
    if (got !== exp)
      report_problem($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_data(input string name, input dram_data_t got, input dram_data_t exp);
    if (got !== exp)
      report_problem($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_mshr(input string name, input mshr_id_t got, input mshr_id_t exp);
    if (got !== exp)
      report_problem($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_problem($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic clear_logs();
    req_wnr_q.delete();
    req_addr_q.delete();
    req_wd_q.delete();
    grant_q.delete();
    ret_cid_q.delete();
    ret_data_q.delete();
    ret_mshr_q.delete();
  endtask

  task automatic wait_reqs(input int n);
    int cycles = 0;
    while (req_addr_q.size() < n && cycles < WAIT_LIMIT) begin
      @(negedge core_clk_i);
      cycles++;
    end
    if (req_addr_q.size() < n)
      report_problem($sformatf("timed out waiting for %0d DRAM requests, saw %0d",
                               n, req_addr_q.size()));
  endtask

  task automatic wait_rets(input cache_id_t cid, input int n);
    int cycles = 0;
    while (count_rets(cid) < n && cycles < WAIT_LIMIT) begin
      @(negedge core_clk_i);
      cycles++;
    end
    if (count_rets(cid) < n)
      report_problem($sformatf("timed out waiting for %0d read beats on cache %0d", n, cid));
  endtask

  task automatic wait_writes_retired();
    int cycles = 0;
    while (wr_pend_q.size() != 0 && cycles < WAIT_LIMIT) begin
      @(negedge core_clk_i);
      cycles++;
    end
    if (wr_pend_q.size() != 0)
      report_problem("write-dones still pending at the end of the test");
    repeat (3) @(negedge core_clk_i);
  endtask

  // n packets back to back, next line and next mshr each time
  task automatic send_pkts(input cache_id_t cid, input logic wnr, input mshr_id_t mshr,
                           input logic [31:0] a, input int n);
    dma_pkt_t p;
    int       cycles;
    for (int k = 0; k < n; k++) begin
      p.write_not_read = wnr;
      p.mshr_id        = mshr_id_t'(mshr + k);
      p.addr           = a + k * 32;
      @(posedge core_clk_i);
      dma_pkt_v_i[cid] <= 1'b1;
      dma_pkt_i[cid]   <= p;
      cycles = 0;
      @(negedge core_clk_i);
      while (!dma_pkt_yumi_o[cid] && cycles < WAIT_LIMIT) begin
        @(negedge core_clk_i);
        cycles++;
      end
      if (!dma_pkt_yumi_o[cid])
        report_problem($sformatf("cache %0d packet %0d was never accepted", cid, k));
    end
    @(posedge core_clk_i);
    dma_pkt_v_i[cid] <= 1'b0;
    @(negedge core_clk_i);
  endtask

  task automatic check_reqs(input int first, input cache_id_t cid, input logic wnr,
                            input logic [31:0] a);
    for (int b = 0; b < `NUM_REQ; b++) begin
      if (first + b < req_addr_q.size()) begin
        check_flag("dram_write_not_read_o", req_wnr_q[first + b], wnr);
        check_addr("dram_ch_addr_o", req_addr_q[first + b], exp_addr(cid, a, b));
      end
    end
  endtask

  task automatic expect_req_count(input int n);
    repeat (10) @(negedge core_clk_i);
    if (req_addr_q.size() != n)
      report_problem($sformatf("expected %0d DRAM requests, saw %0d", n, req_addr_q.size()));
  endtask

  task automatic check_returns(input cache_id_t cid, input logic [31:0] a, input mshr_id_t mshr);
    int beat = 0;
    foreach (ret_cid_q[i]) begin
      if (ret_cid_q[i] == cid) begin
        if (beat < `NUM_REQ) begin
          check_data("dma_data_o", ret_data_q[i], data_of(exp_addr(cid, a, beat)));
          check_mshr("dma_mshr_id_o", ret_mshr_q[i], mshr);
        end
        beat++;
      end
    end
    if (beat != `NUM_REQ)
      report_problem($sformatf("cache %0d got %0d read beats, expected %0d", cid, beat, `NUM_REQ));
  endtask

  task automatic end_test(input string name, input int err0);
    if (errors == err0) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", name, errors - err0);
    end
  endtask

  task automatic test_refill_read();
    int err0 = errors;
    clear_logs();
    send_pkts(0, 1'b0, 2'd2, 32'h0012_3440, 1);
    wait_reqs(`NUM_REQ);
    expect_req_count(`NUM_REQ);
    check_reqs(0, 0, 1'b0, 32'h0012_3440);
    wait_rets(0, `NUM_REQ);
    check_returns(0, 32'h0012_3440, 2'd2);
    end_test("refill read", err0);
  endtask

  task automatic test_eviction();
    int err0 = errors;
    clear_logs();
    send_pkts(1, 1'b1, 2'd1, 32'h00ab_cd60, 1);
    wait_reqs(`NUM_REQ);
    expect_req_count(`NUM_REQ);
    check_reqs(0, 1, 1'b1, 32'h00ab_cd60);
    wait_writes_retired();
    end_test("eviction", err0);
  endtask

  task automatic test_read_after_write();
    int err0 = errors;
    int base;
    clear_logs();
    wd_en = 1'b0;  // hold the write-dones back
    send_pkts(0, 1'b1, 2'd1, 32'h0034_5680, 1);
    send_pkts(0, 1'b0, 2'd3, 32'h0034_5680, 1);
    wait_reqs(`NUM_REQ);
    expect_req_count(`NUM_REQ);
    base = wd_total;
    // single write-done pulses with quiet gaps between them
    for (int k = 0; k < `NUM_REQ; k++) begin
      wd_en = 1'b1;
      @(negedge core_clk_i);
      wd_en = 1'b0;
      repeat (8) @(negedge core_clk_i);
      if (k < `NUM_REQ - 1 && req_addr_q.size() != `NUM_REQ)
        report_problem("refill of the evicted line left before its write-dones");
    end
    wd_en = 1'b1;
    wait_reqs(2 * `NUM_REQ);
    check_reqs(0, 0, 1'b1, 32'h0034_5680);
    check_reqs(`NUM_REQ, 0, 1'b0, 32'h0034_5680);
    if (req_wd_q.size() > `NUM_REQ && req_wd_q[`NUM_REQ] != base + `NUM_REQ)
      report_problem("refill request fired before all write-dones of its line");
    wait_rets(0, `NUM_REQ);
    check_returns(0, 32'h0034_5680, 2'd3);
    wait_writes_retired();
    end_test("read after write", err0);
  endtask

  task automatic test_arbitration();
    int err0 = errors;
    clear_logs();
    fork
      send_pkts(0, 1'b0, 2'd0, 32'h0000_1000, 3);
      send_pkts(1, 1'b0, 2'd0, 32'h0000_2000, 3);
    join
    wait_reqs(6 * `NUM_REQ);
    if (grant_q.size() != 6)
      report_problem($sformatf("expected 6 grants, saw %0d", grant_q.size()));
    for (int i = 1; i < grant_q.size(); i++) begin
      if (grant_q[i] == grant_q[i - 1])
        report_problem($sformatf("cache %0d granted twice in a row", grant_q[i]));
    end
    wait_rets(0, 3 * `NUM_REQ);
    wait_rets(1, 3 * `NUM_REQ);
    end_test("arbitration", err0);
  endtask

  task automatic test_back_pressure();
    int         err0   = errors;
    int         cycles = 0;
    dram_addr_t held_addr;
    dram_data_t held_data;
    mshr_id_t   held_mshr;
    clear_logs();
    yumi_en = 1'b0;
    @(posedge core_clk_i);
    dma_data_ready_i[1] <= 1'b0;
    send_pkts(1, 1'b0, 2'd1, 32'h0040_0080, 1);
    while (!dram_req_v_o && cycles < WAIT_LIMIT) begin
      @(negedge core_clk_i);
      cycles++;
    end
    held_addr = dram_ch_addr_o;
    check_addr("dram_ch_addr_o", held_addr, exp_addr(1, 32'h0040_0080, 0));
    repeat (10) begin
      @(negedge core_clk_i);
      check_flag("dram_req_v_o", dram_req_v_o, 1'b1);
      check_addr("dram_ch_addr_o", dram_ch_addr_o, held_addr);
    end
    yumi_en = 1'b1;
    wait_reqs(`NUM_REQ);
    check_reqs(0, 1, 1'b0, 32'h0040_0080);
    cycles = 0;
    while (!dma_data_v_o[1] && cycles < WAIT_LIMIT) begin
      @(negedge core_clk_i);
      cycles++;
    end
    held_data = dma_data_o[1];
    held_mshr = dma_mshr_id_o[1];
    repeat (10) begin
      @(negedge core_clk_i);
      check_flag("dma_data_v_o[1]", dma_data_v_o[1], 1'b1);
      check_data("dma_data_o[1]", dma_data_o[1], held_data);
      check_mshr("dma_mshr_id_o[1]", dma_mshr_id_o[1], held_mshr);
    end
    @(posedge core_clk_i);
    dma_data_ready_i[1] <= 1'b1;
    wait_rets(1, `NUM_REQ);
    check_returns(1, 32'h0040_0080, 2'd1);
    end_test("back-pressure", err0);
  endtask

  initial begin
    #((NUM_TESTS * WAIT_LIMIT + 10) * CLK_PERIOD);
    $display("watchdog expired, the tests did not finish in time");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    void'($urandom(41354));
    repeat (5) @(posedge core_clk_i);
    core_reset_i <= 1'b0;
    @(negedge core_clk_i);
    check_flag("dram_req_v_o", dram_req_v_o, 1'b0);
    if (dma_pkt_yumi_o != '0 || dma_data_v_o != '0)
      report_problem("cache side handshakes are not idle after reset");
    test_refill_read();
    test_eviction();
    test_read_after_write();
    test_arbitration();
    test_back_pressure();
    $display("tests run %0d, tests failed %0d, errors %0d", NUM_TESTS, failed_tests, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+source
source/dma_pkt_pkg.sv
source/dram_chan_pkg.sv
source/bridge_if.sv
source/dma_req_arbiter.sv
source/req_splitter.sv
source/dram_req_queue.sv
source/miss_tracker.sv
source/read_return.sv
source/dram_bridge_top.sv
tb/tb_dram_bridge.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_dram_bridge
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	if echo "$$out" | grep -q "$(PASS_MSG)"; then echo "PASS"; else echo "FAIL"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
